//--- cpuConsts.svh
/*
 * Width and timing constants for the 8-bit accumulator processor.
 */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Data path and register width.
`define CPU_DATA_W 8

// Program counter and flash address width. Up to 2048 program bytes.
`define CPU_ADDR_W 11

// Number of on-board LEDs, all active low.
`define CPU_LED_W 6

// Screen character index width, for 64 character cells.
`define CPU_CHAR_IDX_W 6

// Clock cycles per millisecond at 27 MHz.
`define CPU_MS_TICKS 27000

// Tick counter width. It must hold CPU_MS_TICKS.
`define CPU_MS_CNT_W 16

// Number of sequencer states, used to size the state encoding.
`define CPU_SEQ_STATES 9

`endif

//--- cpuDatapath.sv
/*
 * Register datapath. Holds a, b, c, ac and the LEDs, executes instructions
 * and drives the screen write port.
 */
`include "cpuConsts.svh"

module cpuDatapath (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       btn,
  execIf.dp                          exec,
  output logic [`CPU_LED_W-1:0]      leds,
  output logic [`CPU_DATA_W-1:0]     cpuChar,
  output logic [`CPU_CHAR_IDX_W-1:0] cpuCharIndex,
  output logic                       writeScreen
);

  logic [`CPU_DATA_W-1:0] a, b, c, ac; // The four ISA registers.
  logic [`CPU_LED_W-1:0]  ledReg;      // Active low, so all ones is all off.
  logic [3:0]             variant;

  assign variant = exec.cmd.variant;
  assign leds    = ledReg;

  // Variant bits are decoded from bit 0 upward. With no bit set ac is used.
  always_comb begin
    if (variant[0])      exec.regOperand = ac;
    else if (variant[1]) exec.regOperand = c;
    else if (variant[2]) exec.regOperand = b;
    else if (variant[3]) exec.regOperand = a;
    else                 exec.regOperand = ac;
  end

  assign exec.acZero = (ac == '0); // JMPZ condition.

  always_ff @(posedge clk) begin
    if (reset) begin
      a           <= '0;
      b           <= '0;
      c           <= '0;
      ac          <= '0;
      ledReg      <= '1;
      writeScreen <= 1'b0;
    end else begin
      // Screen write goes high the cycle after a PRNT execute, for one cycle.
      writeScreen <= exec.execute && (exec.cmd.opcode == cpuPkg::opPrnt);
      if (exec.execute) begin
        case (exec.cmd.opcode)
          cpuPkg::opClr: begin
            if (variant[0]) ac <= '0;
            else if (variant[1]) begin
              // CLR BTN. A press clears ac, otherwise ac collapses to 1 or stays 0.
              if (btn) ac <= '0;
              else ac <= (ac != '0) ? `CPU_DATA_W'(1) : '0;
            end
            else if (variant[2]) b <= '0;
            else if (variant[3]) a <= '0;
          end
          cpuPkg::opAdd: ac <= ac + exec.operand; // Wraps at 8 bits.
          cpuPkg::opSta: begin
            if (variant[0]) ledReg <= ~ac[`CPU_LED_W-1:0]; // Low bits of ac, inverted.
            else if (variant[1]) c <= ac;
            else if (variant[2]) b <= ac;
            else if (variant[3]) a <= ac;
          end
          cpuPkg::opInv: begin
            if (variant[0]) ac <= ~ac;
            else if (variant[1]) c <= ~c;
            else if (variant[2]) b <= ~b;
            else if (variant[3]) a <= ~a;
          end
          default: ; // JMPZ, WAIT and HLT act in the sequencer.
        endcase
      end
    end
  end

  // Character and index only change on a PRNT, so they hold through the write cycle.
  always_ff @(posedge clk) begin
    if (exec.execute && (exec.cmd.opcode == cpuPkg::opPrnt)) begin
      cpuChar      <= exec.operand;
      cpuCharIndex <= ac[`CPU_CHAR_IDX_W-1:0]; // 64 screen cells.
    end
  end

  // Each PRNT gives exactly one write cycle.
  assert property (@(posedge clk) disable iff (reset) writeScreen |=> !writeScreen);

endmodule

//--- cpuPkg.sv
/*
 * Shared types of the processor: opcodes, the command byte layout,
 * the two readings of a flash byte and the sequencer states.
 */
`include "cpuConsts.svh"

package cpuPkg;

  // The three opcode bits of a command byte.
  typedef enum logic [2:0] {
    opClr  = 3'd0, // Clear a register, or the button-conditional clear of ac.
    opAdd  = 3'd1, // ac gets ac plus operand.
    opSta  = 3'd2, // Store ac to a, b, c or the LEDs.
    opInv  = 3'd3, // Invert a register.
    opPrnt = 3'd4, // Write operand to the screen cell indexed by ac.
    opJmpz = 3'd5, // Jump to operand when ac is zero.
    opWait = 3'd6, // Wait operand+1 milliseconds.
    opHlt  = 3'd7  // Stop fetching until reset.
  } opcodeT;

  // Layout of an instruction byte, MSB first.
  typedef struct packed {
    logic   isConst; // Set when a constant operand byte follows.
    opcodeT opcode;
    logic [3:0] variant; // Bit 3 a, bit 2 b, bit 1 c, bit 0 ac or LED.
  } cmdByteT;

  // A byte from flash is either an instruction or a constant operand.
  typedef union packed {
    cmdByteT cmd;
    logic [`CPU_DATA_W-1:0] raw;
  } flashByteU;

  // Sequencer states. The two read states are shared by fetch and retrieve.
  typedef enum logic [$clog2(`CPU_SEQ_STATES)-1:0] {
    sFetch,    // Issue a read of the instruction byte at pc.
    sReadLow,  // Wait for the flash to drop ready.
    sReadHigh, // Wait for ready and capture the byte.
    sDecode,   // Pick the register operand or go fetch a constant.
    sRetrieve, // Issue a read of the constant operand byte.
    sExecute,  // One-cycle execute strobe.
    sPrint,    // Extra cycle while the screen write happens.
    sWait,     // Stall until the millisecond timer is done.
    sHalt      // Nothing more until reset.
  } seqStateT;

endpackage

//--- cpuSequencer.sv
/*
 * Instruction sequencer. Fetches, decodes, retrieves operands and drives
 * the execute strobe, sharing one flash read sequence between fetch and retrieve.
 */
`include "cpuConsts.svh"

module cpuSequencer (
  input  logic                   clk,
  input  logic                   reset,
  execIf.seq                     exec,
  output logic [`CPU_ADDR_W-1:0] flashReadAddr,
  output logic                   enableFlash,
  input  logic                   flashDataReady,
  input  logic [`CPU_DATA_W-1:0] flashByteRead,
  output logic                   timerStart,
  output logic [`CPU_DATA_W-1:0] timerMs,
  input  logic                   timerDone
);

  cpuPkg::seqStateT state;   // Current state.
  cpuPkg::seqStateT readRet; // Where the read sequence goes once the byte is in.
  logic [`CPU_ADDR_W-1:0] pc;         // Address of the next byte to read.
  cpuPkg::flashByteU      command;    // Instruction byte of the current instruction.
  logic [`CPU_DATA_W-1:0] operand;    // Constant operand or selected register.
  cpuPkg::flashByteU      flashWord;  // The raw flash byte, viewed either way.

  assign flashWord = flashByteRead;

  // The execute strobe is the execute state itself, which lasts one cycle.
  assign exec.execute = (state == cpuPkg::sExecute);
  assign exec.cmd     = command.cmd;
  assign exec.operand = operand;

  // WAIT hands its operand to the timer in the execute cycle.
  assign timerStart = exec.execute && (command.cmd.opcode == cpuPkg::opWait);
  assign timerMs    = operand;

  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= cpuPkg::sFetch;
      readRet       <= cpuPkg::sDecode;
      pc            <= '0;
      flashReadAddr <= '0;
      enableFlash   <= 1'b0;
    end else begin
      case (state)
        cpuPkg::sFetch: begin
          if (!enableFlash) begin // Only start once the last request is gone.
            flashReadAddr <= pc;
            enableFlash   <= 1'b1;
            readRet       <= cpuPkg::sDecode;
            state         <= cpuPkg::sReadLow;
          end
        end
        cpuPkg::sRetrieve: begin
          if (!enableFlash) begin
            flashReadAddr <= pc;
            enableFlash   <= 1'b1;
            readRet       <= cpuPkg::sExecute;
            state         <= cpuPkg::sReadLow;
          end
        end
        // Seeing ready low first keeps a stale ready from the last read out.
        cpuPkg::sReadLow: begin
          if (!flashDataReady) state <= cpuPkg::sReadHigh;
        end
        cpuPkg::sReadHigh: begin
          if (flashDataReady) begin
            // The same byte is an instruction after a fetch and a constant after a retrieve.
            if (readRet == cpuPkg::sDecode) command <= flashWord;
            else operand <= flashWord.raw;
            enableFlash <= 1'b0;
            pc          <= pc + `CPU_ADDR_W'(1); // Step past the byte just read.
            state       <= readRet;
          end
        end
        cpuPkg::sDecode: begin
          if (command.cmd.isConst) begin
            state <= cpuPkg::sRetrieve; // The operand is the next flash byte.
          end else begin
            operand <= exec.regOperand; // Latch the register picked by the variant bits.
            state   <= cpuPkg::sExecute;
          end
        end
        cpuPkg::sExecute: begin
          state <= cpuPkg::sFetch; // Most instructions finish here.
          case (command.cmd.opcode)
            cpuPkg::opPrnt: state <= cpuPkg::sPrint;
            cpuPkg::opJmpz: begin
              if (exec.acZero) pc <= `CPU_ADDR_W'(operand); // Targets reach the first 256 bytes only.
            end
            cpuPkg::opWait: state <= cpuPkg::sWait;
            cpuPkg::opHlt:  state <= cpuPkg::sHalt;
            default: ;
          endcase
        end
        cpuPkg::sPrint: state <= cpuPkg::sFetch; // The datapath writes the screen in this cycle.
        cpuPkg::sWait: begin
          if (timerDone) state <= cpuPkg::sFetch; // Done goes low the cycle after start.
        end
        cpuPkg::sHalt: ; // Stay here until reset.
        default: state <= cpuPkg::sFetch;
      endcase
    end
  end

  // A flash request is held until the flash reports the byte, so no new one can overlap it.
  assert property (@(posedge clk) disable iff (reset)
    enableFlash && !flashDataReady |=> enableFlash);

  // Execute is a one-cycle pulse per instruction.
  assert property (@(posedge clk) disable iff (reset)
    exec.execute |=> !exec.execute);

endmodule

//--- cpuTop.sv
/*
 * Accumulator processor top level. Connects the sequencer, the wait timer
 * and the register datapath to the flash, LEDs and screen.
 */
`include "cpuConsts.svh"

module cpuTop #(
  parameter int unsigned msTicks = `CPU_MS_TICKS
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       btn,
  output logic [`CPU_ADDR_W-1:0]     flashReadAddr,
  output logic                       enableFlash,
  input  logic                       flashDataReady,
  input  logic [`CPU_DATA_W-1:0]     flashByteRead,
  output logic [`CPU_LED_W-1:0]      leds,
  output logic [`CPU_DATA_W-1:0]     cpuChar,
  output logic [`CPU_CHAR_IDX_W-1:0] cpuCharIndex,
  output logic                       writeScreen
);

  logic                   timerStart;
  logic [`CPU_DATA_W-1:0] timerMs;
  logic                   timerDone;

  execIf execBus (); // Instruction and operand to the datapath.

  cpuSequencer uSequencer (
    .clk            (clk),
    .reset          (reset),
    .exec           (execBus.seq),
    .flashReadAddr  (flashReadAddr),
    .enableFlash    (enableFlash),
    .flashDataReady (flashDataReady),
    .flashByteRead  (flashByteRead),
    .timerStart     (timerStart),
    .timerMs        (timerMs),
    .timerDone      (timerDone)
  );

  waitTimer #(.ticksPerMs(msTicks)) uWaitTimer (
    .clk     (clk),
    .reset   (reset),
    .start   (timerStart),
    .msCount (timerMs),
    .done    (timerDone)
  );

  cpuDatapath uDatapath (
    .clk          (clk),
    .reset        (reset),
    .btn          (btn),
    .exec         (execBus.dp),
    .leds         (leds),
    .cpuChar      (cpuChar),
    .cpuCharIndex (cpuCharIndex),
    .writeScreen  (writeScreen)
  );

endmodule

//--- execIf.sv
/*
 * Execute bus between the sequencer and the register datapath.
 */
`include "cpuConsts.svh"

interface execIf;

  logic                   execute;    // Single-cycle strobe in the execute state.
  cpuPkg::cmdByteT        cmd;        // Current instruction.
  logic [`CPU_DATA_W-1:0] operand;    // Constant or selected register value.
  logic [`CPU_DATA_W-1:0] regOperand; // Register picked by the variant bits.
  logic                   acZero;     // High while ac holds zero.

  // The sequencer owns the instruction and asks for the register operand.
  modport seq (
    output execute,
    output cmd,
    output operand,
    input  regOperand,
    input  acZero
  );

  // The datapath executes and reports its register state back.
  modport dp (
    input  execute,
    input  cmd,
    input  operand,
    output regOperand,
    output acZero
  );

endinterface

//--- run.sh
#!/bin/sh
# Build and run the processor testbench with Verilator.
verilator --binary --timing --assert -f tb.f --top-module tbCpu -o tbSim > build.log 2>&1 \
  || { cat build.log; exit 1; }
./obj_dir/tbSim > sim.log 2>&1 || true
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || exit 1
exit 0

//--- tb.f
+incdir+.
cpuPkg.sv
execIf.sv
cpuSequencer.sv
waitTimer.sv
cpuDatapath.sv
cpuTop.sv
tbFlash.sv
tbCpu.sv

//--- tbCpu.sv
/*
 * Testbench for the accumulator processor. Runs random programs from the
 * flash model and checks LEDs and screen writes against an ISA model.
 */
`include "cpuConsts.svh"

module tbCpu;

  localparam int numTests  = 12;
  localparam int maxInstr  = 20;
  localparam int maxBytes  = 2 * maxInstr + 1;  // Every instruction with a constant, plus HLT.
  localparam int maxWaitMs = maxInstr * 4;      // WAIT operands go up to 3, so 4 ms each.
  localparam int msCycles  = 21;                // msTicks of 20 gives 21 cycles per ms.

  logic                       clk;
  logic                       reset;
  logic                       btn;
  logic [`CPU_ADDR_W-1:0]     flashReadAddr;
  logic                       enableFlash;
  logic                       flashDataReady;
  logic [`CPU_DATA_W-1:0]     flashByteRead;
  logic [`CPU_LED_W-1:0]      leds;
  logic [`CPU_DATA_W-1:0]     cpuChar;
  logic [`CPU_CHAR_IDX_W-1:0] cpuCharIndex;
  logic                       writeScreen;

  int seed;
  int errors;      // All failed checks of the run.
  int testErrors;  // Failed checks of the current test.

  // The program in instruction form, and as flash bytes.
  int opc [0:maxInstr];
  int isc [0:maxInstr];
  int vr [0:maxInstr];
  int opnd [0:maxInstr];
  int addr [0:maxInstr];
  logic [`CPU_DATA_W-1:0] img [0:255];
  int progLen;

  // Expected events from the model, in order.
  logic [`CPU_LED_W-1:0]      expLeds [$];
  logic [`CPU_DATA_W-1:0]     expChar [$];
  logic [`CPU_CHAR_IDX_W-1:0] expIdx [$];
  int                         expGap [$]; // Minimum cycles since the last screen write.
  logic [`CPU_ADDR_W-1:0]     expAddr [$]; // Flash addresses in the order they are read.
  int                         expReads;

  // Monitor state.
  logic                  running;
  int                    cycle;
  int                    lastWrite;
  int                    readsSeen;
  logic                  prevWs;
  logic                  prevEn;
  logic [`CPU_LED_W-1:0] prevLeds;

  cpuTop #(.msTicks(20)) u_cpuTop (
    .clk            (clk),
    .reset          (reset),
    .btn            (btn),
    .flashReadAddr  (flashReadAddr),
    .enableFlash    (enableFlash),
    .flashDataReady (flashDataReady),
    .flashByteRead  (flashByteRead),
    .leds           (leds),
    .cpuChar        (cpuChar),
    .cpuCharIndex   (cpuCharIndex),
    .writeScreen    (writeScreen)
  );

  tbFlash uFlash (
    .clk         (clk),
    .reset       (reset),
    .enableFlash (enableFlash),
    .addr        (flashReadAddr),
    .ready       (flashDataReady),
    .data        (flashByteRead)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  function automatic int rnd(input int k);
    rnd = int'($unsigned($random(seed)) % k);
  endfunction

  task automatic reportProblem(input string msg);
    $display("Error at %0t: %s", $time, msg);
    errors++;
    testErrors++;
  endtask

  task automatic checkLeds(input logic [`CPU_LED_W-1:0] got, input logic [`CPU_LED_W-1:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t: leds = %h, expected %h", $time, got, exp);
      errors++;
      testErrors++;
    end
  endtask

  task automatic checkAddr(input logic [`CPU_ADDR_W-1:0] got,
                           input logic [`CPU_ADDR_W-1:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t: flashReadAddr = %h, expected %h", $time, got, exp);
      errors++;
      testErrors++;
    end
  endtask

  task automatic checkScreen(input logic [`CPU_DATA_W-1:0] gotChar,
                             input logic [`CPU_CHAR_IDX_W-1:0] gotIdx,
                             input logic [`CPU_DATA_W-1:0] wantChar,
                             input logic [`CPU_CHAR_IDX_W-1:0] wantIdx);
    if (gotChar !== wantChar) begin
      $display("Fail at %0t: cpuChar = %h, expected %h", $time, gotChar, wantChar);
      errors++;
      testErrors++;
    end
    if (gotIdx !== wantIdx) begin
      $display("Fail at %0t: cpuCharIndex = %h, expected %h", $time, gotIdx, wantIdx);
      errors++;
      testErrors++;
    end
  endtask

  // Random body of 10 to 20 instructions, then HLT. Jumps only go forward.
  task automatic genProgram();
    int n;
    int pos;
    int j;
    cpuPkg::flashByteU fb;
    n   = 10 + rnd(11);
    pos = 0;
    for (int i = 0; i < n; i++) begin
      addr[i] = pos;
      opc[i]  = rnd(7); // Anything but HLT.
      vr[i]   = rnd(16);
      isc[i]  = 0;
      opnd[i] = rnd(256);
      case (opc[i])
        0, 1, 2, 3, 4: isc[i] = rnd(2); // Everything but JMPZ and WAIT in both forms.
        5: isc[i] = 1;         // JMPZ target is always a constant.
        6: begin
          isc[i]  = 1;
          opnd[i] = rnd(4);    // Short waits.
        end
        default: ;
      endcase
      pos = pos + 1 + isc[i];
    end
    addr[n] = pos;
    opc[n]  = 7;
    isc[n]  = 0;
    vr[n]   = 0;
    for (int i = 0; i < n; i++) begin
      if (opc[i] == 5) begin
        j       = i + 1 + rnd(n - i); // Lands on a later instruction or the HLT.
        opnd[i] = addr[j];
      end
    end
    for (int i = 0; i <= n; i++) begin
      fb.cmd.isConst = isc[i][0];
      fb.cmd.opcode  = cpuPkg::opcodeT'(opc[i][2:0]);
      fb.cmd.variant = vr[i][3:0];
      img[addr[i]]   = fb.raw;
      if (isc[i] != 0) img[addr[i] + 1] = opnd[i][7:0];
    end
    progLen = pos + 1;
  endtask

  // ISA model. Walks the byte image and records the visible events.
  task automatic runModel();
    logic [`CPU_DATA_W-1:0] ra, rb, rc, ac, op;
    logic [`CPU_LED_W-1:0]  led, nv;
    logic [3:0]             v;
    logic                   halted;
    int                     pc, gap, steps;
    cpuPkg::flashByteU      fb;
    expLeds.delete();
    expChar.delete();
    expIdx.delete();
    expGap.delete();
    expAddr.delete();
    expReads = 0;
    {ra, rb, rc, ac} = '0;
    led = '1;
    halted = 1'b0;
    pc = 0;
    gap = 0;
    steps = 0;
    while (!halted && steps < 1000) begin
      expAddr.push_back(`CPU_ADDR_W'(pc));
      fb.raw = img[pc];
      pc++;
      expReads++;
      v = fb.cmd.variant;
      if (fb.cmd.isConst) begin
        expAddr.push_back(`CPU_ADDR_W'(pc));
        op = img[pc]; // Second byte is the constant.
        pc++;
        expReads++;
      end else if (v[0]) op = ac; // Lowest set variant bit wins.
      else if (v[1]) op = rc;
      else if (v[2]) op = rb;
      else if (v[3]) op = ra;
      else op = ac;
      case (fb.cmd.opcode)
        cpuPkg::opClr: begin
          if (v[0]) ac = 8'd0;
          else if (v[1]) ac = btn ? 8'd0 : ((ac != 8'd0) ? 8'd1 : 8'd0);
          else if (v[2]) rb = 8'd0;
          else if (v[3]) ra = 8'd0;
        end
        cpuPkg::opAdd: ac = ac + op;
        cpuPkg::opSta: begin
          if (v[0]) begin
            nv = ~ac[`CPU_LED_W-1:0];
            if (nv != led) expLeds.push_back(nv); // Only changes are visible.
            led = nv;
          end else if (v[1]) rc = ac;
          else if (v[2]) rb = ac;
          else if (v[3]) ra = ac;
        end
        cpuPkg::opInv: begin
          if (v[0]) ac = ~ac;
          else if (v[1]) rc = ~rc;
          else if (v[2]) rb = ~rb;
          else if (v[3]) ra = ~ra;
        end
        cpuPkg::opPrnt: begin
          expChar.push_back(op);
          expIdx.push_back(ac[`CPU_CHAR_IDX_W-1:0]);
          expGap.push_back(gap);
          gap = 0;
        end
        cpuPkg::opJmpz: if (ac == 8'd0) pc = int'(op);
        cpuPkg::opWait: gap = gap + (int'(op) + 1) * msCycles;
        default: halted = 1'b1;
      endcase
      steps++;
    end
  endtask

  // Outputs are sampled on the falling edge, half a cycle after they change.
  always @(negedge clk) begin
    if (running) begin
      cycle++;
      if (leds !== prevLeds) begin
        if (expLeds.size() == 0) reportProblem("leds changed with no LED update expected");
        else checkLeds(leds, expLeds.pop_front());
      end
      prevLeds = leds;
      if (writeScreen) begin
        if (prevWs) reportProblem("writeScreen stayed high for more than one cycle");
        if (expChar.size() == 0) begin
          reportProblem("screen write with no PRNT expected");
        end else begin
          checkScreen(cpuChar, cpuCharIndex, expChar.pop_front(), expIdx.pop_front());
          if (cycle - lastWrite < expGap.pop_front()) reportProblem("WAIT ended too early");
        end
        lastWrite = cycle;
      end
      prevWs = writeScreen;
      if (enableFlash && !prevEn) begin // One rising edge per flash read.
        readsSeen++;
        if (expAddr.size() == 0) reportProblem("flash read after the program should have halted");
        else checkAddr(flashReadAddr, expAddr.pop_front());
      end
      prevEn = enableFlash;
    end
  end

  task automatic runTest(input int t);
    int nLeds;
    int nWrites;
    running = 1'b0;
    genProgram();
    btn = rnd(2) != 0; // Held for the whole program.
    runModel();
    nLeds   = expLeds.size();
    nWrites = expChar.size();
    for (int i = 0; i < progLen; i++) uFlash.mem[i] = img[i];
    testErrors = 0;
    reset = 1'b1;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    checkLeds(leds, '1);
    if (enableFlash !== 1'b0 || writeScreen !== 1'b0)
      reportProblem("enableFlash or writeScreen high after reset");
    cycle     = 0;
    lastWrite = 0;
    readsSeen = 0;
    prevWs    = 1'b0;
    prevEn    = 1'b0;
    prevLeds  = '1;
    running   = 1'b1;
    while (readsSeen < expReads || enableFlash) @(negedge clk);
    repeat (200) @(negedge clk); // The HLT must keep the flash quiet.
    running = 1'b0;
    if (readsSeen != expReads) reportProblem("flash read count differs from the program");
    if (expLeds.size() != 0 || expChar.size() != 0)
      reportProblem("expected LED or screen events never appeared");
    $display("test %0d: %0d bytes, btn %0d, %0d LED updates, %0d screen writes, %0d errors",
             t, progLen, btn, nLeds, nWrites, testErrors);
  endtask

  initial begin
    seed    = 32'h819a;
    errors  = 0;
    reset   = 1'b1;
    btn     = 1'b0;
    running = 1'b0;
    for (int t = 0; t < numTests; t++) runTest(t);
    $display("%0d tests run, %0d errors", numTests, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Worst-case run length, with a margin of four for each wait.
  initial begin
    longint limitCycles;
    limitCycles = longint'(numTests) * (maxBytes * 40 + maxWaitMs * msCycles * 4 + 200 + 10);
    #(limitCycles * 10);
    $display("Timeout: the run did not finish in %0d cycles", limitCycles);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- tbFlash.sv
/*
 * Flash model for the testbench. Holds a program image and answers
 * each read after a random delay of 1 to 4 cycles.
 */
`include "cpuConsts.svh"

module tbFlash (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   enableFlash,
  input  logic [`CPU_ADDR_W-1:0] addr,
  output logic                   ready,
  output logic [`CPU_DATA_W-1:0] data
);

  logic [`CPU_DATA_W-1:0] mem [0:(1 << `CPU_ADDR_W)-1]; // Program image, written by the testbench.
  int   seed;    // Own random stream for the ready delay.
  int   delay;   // Cycles left before ready rises.
  logic pending; // A request has been seen and its delay is counting.

  initial begin
    seed    = 32'h819a;
    delay   = 0;
    pending = 1'b0;
    ready   = 1'b0;
    data    = '0;
  end

  // Outputs change on the falling edge so the DUT samples them stable.
  always @(negedge clk) begin
    if (reset || !enableFlash) begin
      ready   <= 1'b0; // Dropping the request ends the read.
      pending = 1'b0;
    end else if (!ready) begin
      if (!pending) begin
        pending = 1'b1;
        delay   = $unsigned($random(seed)) % 4; // One to four cycles in total.
      end else if (delay == 0) begin
        ready <= 1'b1;
        data  <= mem[addr];
      end else begin
        delay = delay - 1;
      end
    end
  end

endmodule

//--- waitTimer.sv
/*
 * Millisecond wait timer. Counts msCount+1 periods of ticksPerMs+1 cycles.
 */
`include "cpuConsts.svh"

module waitTimer #(
  parameter int unsigned ticksPerMs = `CPU_MS_TICKS
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  logic [`CPU_DATA_W-1:0] msCount,
  output logic                   done
);

  localparam logic [`CPU_MS_CNT_W-1:0] tickLast = `CPU_MS_CNT_W'(ticksPerMs);

  logic [`CPU_MS_CNT_W-1:0] tickCnt; // Cycles into the current millisecond.
  logic [`CPU_DATA_W-1:0]   msLeft;  // Milliseconds still to go after this one.
  logic                     busy;

  assign done = !busy; // Idle counts as done.

  always_ff @(posedge clk) begin
    if (reset) begin
      busy    <= 1'b0;
      tickCnt <= '0;
      msLeft  <= '0;
    end else if (start) begin
      busy    <= 1'b1;
      tickCnt <= '0;
      msLeft  <= msCount;
    end else if (busy) begin
      if (tickCnt == tickLast) begin // One millisecond is over.
        tickCnt <= '0;
        if (msLeft == '0) busy <= 1'b0;
        else msLeft <= msLeft - `CPU_DATA_W'(1);
      end else begin
        tickCnt <= tickCnt + `CPU_MS_CNT_W'(1);
      end
    end
  end

  // The sequencer only starts a wait once the previous one is over.
  assert property (@(posedge clk) disable iff (reset) start |-> done);

endmodule
